/* common/pgwr_pkg.sv */
/*
 * shared definitions of the page-table write manager
 * table bases, ATT and list entry layouts, list/status/write-kind/state enums
 * and the entry address helpers
 */
`default_nettype none

package pgwr_pkg;

	typedef logic [63:0]  addr_t;	// byte address of a table write
	typedef logic [127:0] line_t;	// one write beat
	typedef logic [15:0]  strb_t;
	typedef logic [31:0]  ptr_t;	// list entry index, 1-based
	typedef logic [55:0]  way_t;

	localparam ptr_t  NULL_PTR  = 32'd0;	// no entry
	localparam addr_t ATT_BASE  = 64'h0000_0000_8000_0000;
	localparam addr_t LIST_BASE = 64'h0000_0000_8001_0000;
	localparam way_t  PPA_BASE  = 56'h0000_0000_0800_00;	// first physical page number

	typedef enum logic [1:0] {
		DALLOC = 2'd0,
		UNCOMP = 2'd1,
		COMP   = 2'd2
	} att_sts_e;

	typedef enum logic {
		FREE       = 1'b0,
		UNCOMP_LST = 1'b1
	} lst_e;

	// 64-bit ATT entry, two per beat
	typedef struct packed {
		logic [5:0] zpd_cnt;
		way_t       way;
		att_sts_e   sts;
	} att_entry_t;

	// 128-bit list entry, next sits in the low bytes
	typedef struct packed {
		logic [7:0] rsvd;	// byte 15
		way_t       way;	// bytes 8..14
		ptr_t       prev;	// bytes 4..7
		ptr_t       next;	// bytes 0..3
	} lst_entry_t;

	typedef enum logic [2:0] {
		ATT_INIT,
		LST_INIT,
		ATT_UPD,
		POP,
		PUSH_SELF,
		PUSH_LINK
	} wr_kind_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT_ATT,
		ST_INIT_LIST,
		ST_ATT_UPD,
		ST_POP,
		ST_PUSH_SELF,
		ST_PUSH_LINK,
		ST_WAIT_RESP
	} state_e;

	// head/tail register operations
	typedef enum logic [1:0] {
		HT_NOP,
		HT_INIT,
		HT_POP,
		HT_PUSH
	} ht_op_e;

	typedef struct packed {
		ht_op_e op;
		lst_e   lst;
		ptr_t   entry;	// new head on pop, new tail on push
		ptr_t   len;	// list length for init
	} ht_cmd_t;

	// beat address holding ATT entry n
	function automatic addr_t att_addr(ptr_t n);
		return ATT_BASE + (((addr_t'(n) - 64'd1) >> 1) << 4);
	endfunction

	// beat address of list entry n
	function automatic addr_t lst_addr(ptr_t n);
		return LIST_BASE + ((addr_t'(n) - 64'd1) << 4);
	endfunction

endpackage

`default_nettype wire

/* common/wr_req_if.sv */
/*
 * write request channel from the control FSM to the AXI write port
 */
`default_nettype none

interface wr_req_if;
	import pgwr_pkg::*;

	logic  valid;	// held until ready
	logic  ready;	// port has no AW or W beat pending
	addr_t addr;
	line_t data;
	strb_t strb;
	logic  done;	// no write response outstanding

	modport src (
		output valid, addr, data, strb,
		input  ready, done
	);

	modport port (
		input  valid, addr, data, strb,
		output ready, done
	);

	modport mon (
		input valid, ready, addr, data, strb, done
	);

endinterface

`default_nettype wire

/* pgwr/list_ht_regs.sv */
/*
 * head and tail registers of the free and uncompressed lists
 */
`default_nettype none

module list_ht_regs (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  pgwr_pkg::ht_cmd_t ht_cmd,
	output pgwr_pkg::ptr_t    free_head,
	output pgwr_pkg::ptr_t    free_tail,
	output pgwr_pkg::ptr_t    uncomp_head,
	output pgwr_pkg::ptr_t    uncomp_tail
);
	import pgwr_pkg::*;

	ptr_t head_q [2];	// indexed by lst_e
	ptr_t tail_q [2];
	ptr_t cur_head, cur_tail;

	assign cur_head = head_q[ht_cmd.lst];
	assign cur_tail = tail_q[ht_cmd.lst];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head_q <= '{NULL_PTR, NULL_PTR};
			tail_q <= '{NULL_PTR, NULL_PTR};
		end else begin
			case (ht_cmd.op)
				HT_INIT: begin
					head_q[ht_cmd.lst] <= 32'd1;
					tail_q[ht_cmd.lst] <= ht_cmd.len;
				end
				HT_POP: begin
					if (cur_head == cur_tail) begin	// single entry, list now empty
						head_q[ht_cmd.lst] <= NULL_PTR;
						tail_q[ht_cmd.lst] <= NULL_PTR;
					end else begin
						head_q[ht_cmd.lst] <= ht_cmd.entry;
					end
				end
				HT_PUSH: begin
					tail_q[ht_cmd.lst] <= ht_cmd.entry;
					if (cur_tail == NULL_PTR) begin
						head_q[ht_cmd.lst] <= ht_cmd.entry;	// was empty
					end
				end
				default: ;
			endcase
		end
	end

	assign free_head   = head_q[FREE];
	assign free_tail   = tail_q[FREE];
	assign uncomp_head = head_q[UNCOMP_LST];
	assign uncomp_tail = tail_q[UNCOMP_LST];

endmodule

`default_nettype wire

/* pgwr/tbl_init_gen.sv */
/*
 * entry counter and write formation for ATT and list initialisation
 */
`default_nettype none

module tbl_init_gen #(
	parameter int ATT_ENTRIES  = 16,
	parameter int LIST_ENTRIES = 8,
	parameter int PWRUP_UNCOMP = 0
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               init_step,
	input  pgwr_pkg::wr_kind_e init_table,	// LST_INIT selects the list table
	output pgwr_pkg::addr_t    addr,
	output pgwr_pkg::line_t    data,
	output pgwr_pkg::strb_t    strb,
	output logic               last
);
	import pgwr_pkg::*;

	ptr_t       cnt;	// current entry, from 1
	logic       is_lst;
	way_t       ppa;
	att_entry_t att_ent;
	lst_entry_t lst_ent;

	assign is_lst = (init_table == LST_INIT);
	assign last   = is_lst ? (cnt == ptr_t'(LIST_ENTRIES)) : (cnt == ptr_t'(ATT_ENTRIES));
	assign ppa    = PPA_BASE + way_t'(cnt - 32'd1);	// one page per entry

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt <= 32'd1;
		end else if (init_step) begin
			cnt <= last ? 32'd1 : cnt + 32'd1;	// restart for the next table
		end
	end

	always_comb begin
		att_ent.zpd_cnt = '0;
		if (PWRUP_UNCOMP == 1 && cnt <= ptr_t'(LIST_ENTRIES)) begin
			att_ent.sts = UNCOMP;	// first pages come up uncompressed
			att_ent.way = ppa;
		end else begin
			att_ent.sts = DALLOC;
			att_ent.way = '0;
		end

		lst_ent.rsvd = '0;
		lst_ent.way  = ppa;
		lst_ent.prev = cnt - 32'd1;	// entry 1 gets NULL_PTR
		lst_ent.next = (cnt == ptr_t'(LIST_ENTRIES)) ? NULL_PTR : cnt + 32'd1;

		if (is_lst) begin
			addr = lst_addr(cnt);
			data = lst_ent;
			strb = '1;
		end else begin
			addr = att_addr(cnt);
			data = {att_ent, att_ent};
			strb = cnt[0] ? 16'h00ff : 16'hff00;	// odd entries in the low lane
		end
	end

endmodule

`default_nettype wire

/* pgwr/tbl_upd_gen.sv */
/*
 * write formation for a table update
 * ATT entry write, pop of the source head, push of P onto the destination tail
 */
`default_nettype none

module tbl_upd_gen (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               upd_latch,
	input  pgwr_pkg::ptr_t     upd_att_id,
	input  pgwr_pkg::lst_e     upd_src,
	input  pgwr_pkg::lst_e     upd_dst,
	input  logic               upd_att_only,
	input  pgwr_pkg::att_sts_e upd_att_sts,
	input  pgwr_pkg::way_t     upd_way,
	input  pgwr_pkg::ptr_t     upd_next,
	input  pgwr_pkg::ptr_t     src_head,
	input  pgwr_pkg::ptr_t     dst_tail,	// still the old tail during PUSH_LINK
	input  pgwr_pkg::wr_kind_e wr_kind,
	output pgwr_pkg::addr_t    addr,
	output pgwr_pkg::line_t    data,
	output pgwr_pkg::strb_t    strb
);
	import pgwr_pkg::*;

	ptr_t       att_id_q;
	att_sts_e   sts_q;
	way_t       way_q;
	ptr_t       next_q;
	ptr_t       p_q;	// popped entry
	att_entry_t att_ent;
	lst_entry_t lst_ent;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			att_id_q <= NULL_PTR;
			sts_q    <= DALLOC;
			way_q    <= '0;
			next_q   <= NULL_PTR;
			p_q      <= NULL_PTR;
		end else if (upd_latch) begin
			att_id_q <= upd_att_id;
			way_q    <= upd_way;
			next_q   <= upd_next;
			p_q      <= src_head;
			if (upd_att_only) begin
				sts_q <= upd_att_sts;
			end else if (upd_src == FREE && upd_dst == UNCOMP_LST) begin
				sts_q <= UNCOMP;	// fresh page allocated
			end else begin
				sts_q <= COMP;	// page got compressed, way freed
			end
		end
	end

	always_comb begin
		att_ent = '{zpd_cnt: '0, way: way_q, sts: sts_q};
		lst_ent = '0;	// untouched fields are masked by strb
		addr    = '0;
		data    = '0;
		strb    = '0;
		case (wr_kind)
			ATT_UPD: begin
				addr = att_addr(att_id_q);
				data = {att_ent, att_ent};
				strb = att_id_q[0] ? 16'h00ff : 16'hff00;
			end
			POP: begin
				lst_ent.prev = NULL_PTR;	// successor becomes the new head
				addr = lst_addr(next_q);
				data = lst_ent;
				strb = 16'h00f0;	// prev only
			end
			PUSH_SELF: begin
				lst_ent.prev = dst_tail;
				lst_ent.next = NULL_PTR;
				addr = lst_addr(p_q);
				data = lst_ent;
				strb = 16'h00ff;	// prev and next
			end
			PUSH_LINK: begin
				lst_ent.next = p_q;	// old tail points at P
				addr = lst_addr(dst_tail);
				data = lst_ent;
				strb = 16'h000f;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* pgwr/pgwr_ctrl.sv */
/*
 * sequencing FSM of the write manager
 * runs ATT/list init and the update write sequence, waits for responses,
 * selects the generator that feeds the write channel and drives head/tail updates
 */
`default_nettype none

module pgwr_ctrl #(
	parameter int LIST_ENTRIES = 8
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               init_att,
	input  logic               init_list,
	input  logic               upd_valid,
	input  logic               upd_att_only,
	input  pgwr_pkg::lst_e     upd_src,
	input  pgwr_pkg::lst_e     upd_dst,
	input  pgwr_pkg::ptr_t     upd_next,
	input  pgwr_pkg::ptr_t     free_head,
	input  pgwr_pkg::ptr_t     free_tail,
	input  pgwr_pkg::ptr_t     uncomp_head,
	input  pgwr_pkg::ptr_t     uncomp_tail,
	input  logic               init_last,
	input  pgwr_pkg::addr_t    init_addr,
	input  pgwr_pkg::line_t    init_data,
	input  pgwr_pkg::strb_t    init_strb,
	input  pgwr_pkg::addr_t    upd_addr,
	input  pgwr_pkg::line_t    upd_data,
	input  pgwr_pkg::strb_t    upd_strb,
	wr_req_if.src              wr,
	output logic               init_step,
	output pgwr_pkg::wr_kind_e wr_kind,
	output logic               upd_latch,
	output pgwr_pkg::ptr_t     src_head,
	output pgwr_pkg::ptr_t     dst_tail,
	output pgwr_pkg::ht_cmd_t  ht_cmd,
	output logic               init_att_done,
	output logic               init_list_done,
	output logic               mngr_ready,
	output logic               tbl_update_done
);
	import pgwr_pkg::*;

	state_e   state, state_n;
	wr_kind_e kind_q;	// kind of the last accepted write
	lst_e     src_q, dst_q;
	logic     att_only_q;
	ptr_t     p_q;	// popped entry
	ptr_t     next_q;
	lst_e     src_sel;
	ptr_t     src_tail;
	logic     acc;
	logic     init_att_go, init_list_go, upd_go;

	assign acc          = wr.valid && wr.ready;
	assign init_att_go  = init_att && !init_att_done;
	assign init_list_go = init_list && !init_list_done;
	assign upd_go       = upd_valid && !init_att_go && !init_list_go;	// init has priority

	// raw source while idle so the popped entry is latched with the request
	assign src_sel  = (state == ST_IDLE) ? upd_src : src_q;
	assign src_head = (src_sel == FREE) ? free_head : uncomp_head;
	assign src_tail = (src_sel == FREE) ? free_tail : uncomp_tail;
	assign dst_tail = (dst_q == FREE) ? free_tail : uncomp_tail;

	always_comb begin
		case (state)
			ST_INIT_ATT:  wr_kind = ATT_INIT;
			ST_INIT_LIST: wr_kind = LST_INIT;
			ST_ATT_UPD:   wr_kind = ATT_UPD;
			ST_POP:       wr_kind = POP;
			ST_PUSH_SELF: wr_kind = PUSH_SELF;
			ST_PUSH_LINK: wr_kind = PUSH_LINK;
			default:      wr_kind = kind_q;	// idle and response wait
		endcase
	end

	assign wr.valid = !(state inside {ST_IDLE, ST_WAIT_RESP});
	assign wr.addr  = (wr_kind inside {ATT_INIT, LST_INIT}) ? init_addr : upd_addr;
	assign wr.data  = (wr_kind inside {ATT_INIT, LST_INIT}) ? init_data : upd_data;
	assign wr.strb  = (wr_kind inside {ATT_INIT, LST_INIT}) ? init_strb : upd_strb;

	assign init_step       = acc && (state inside {ST_INIT_ATT, ST_INIT_LIST});
	assign mngr_ready      = (state == ST_IDLE);
	assign upd_latch       = mngr_ready && upd_go;
	assign tbl_update_done = (state == ST_WAIT_RESP) && wr.done
		&& !(kind_q inside {ATT_INIT, LST_INIT});

	// next state, and head/tail change on each accepted write
	always_comb begin
		state_n = state;
		ht_cmd  = '{op: HT_NOP, lst: src_q, entry: NULL_PTR, len: NULL_PTR};
		case (state)
			ST_IDLE: begin
				if (init_att_go) begin
					state_n = ST_INIT_ATT;
				end else if (init_list_go) begin
					state_n = ST_INIT_LIST;
				end else if (upd_go) begin
					state_n = ST_ATT_UPD;
				end
			end
			ST_INIT_ATT: begin
				if (acc && init_last) begin
					state_n = ST_WAIT_RESP;
				end
			end
			ST_INIT_LIST: begin
				if (acc && init_last) begin
					ht_cmd.op  = HT_INIT;	// one long free list
					ht_cmd.lst = FREE;
					ht_cmd.len = ptr_t'(LIST_ENTRIES);
					state_n    = ST_WAIT_RESP;
				end
			end
			ST_ATT_UPD: begin
				if (acc) begin
					if (att_only_q || src_head == NULL_PTR) begin
						state_n = ST_WAIT_RESP;	// nothing to move
					end else if (src_head != src_tail) begin
						state_n = ST_POP;
					end else begin
						ht_cmd.op = HT_POP;	// last entry leaves, list empties without a write
						state_n   = ST_PUSH_SELF;
					end
				end
			end
			ST_POP: begin
				if (acc) begin
					ht_cmd.op    = HT_POP;
					ht_cmd.entry = next_q;	// successor becomes head
					state_n      = ST_PUSH_SELF;
				end
			end
			ST_PUSH_SELF: begin
				if (acc) begin
					if (dst_tail == NULL_PTR) begin
						ht_cmd.op    = HT_PUSH;	// empty destination, P is head and tail
						ht_cmd.lst   = dst_q;
						ht_cmd.entry = p_q;
						state_n      = ST_WAIT_RESP;
					end else begin
						state_n = ST_PUSH_LINK;
					end
				end
			end
			ST_PUSH_LINK: begin
				if (acc) begin
					ht_cmd.op    = HT_PUSH;	// tail moves only once the old tail is linked
					ht_cmd.lst   = dst_q;
					ht_cmd.entry = p_q;
					state_n      = ST_WAIT_RESP;
				end
			end
			ST_WAIT_RESP: begin
				if (wr.done) begin
					state_n = ST_IDLE;
				end
			end
			default: state_n = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state          <= ST_IDLE;
			kind_q         <= ATT_INIT;
			src_q          <= FREE;
			dst_q          <= FREE;
			att_only_q     <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state <= state_n;
			if (acc) begin
				kind_q <= wr_kind;
			end
			if (upd_latch) begin
				src_q      <= upd_src;
				dst_q      <= upd_dst;
				att_only_q <= upd_att_only;
			end
			if (state == ST_WAIT_RESP && wr.done) begin	// flags stay set until reset
				if (kind_q == ATT_INIT) begin
					init_att_done <= 1'b1;
				end
				if (kind_q == LST_INIT) begin
					init_list_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (upd_latch) begin
			p_q    <= src_head;
			next_q <= upd_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/axi_wr_port.sv */
/*
 * AXI write driver, one request at a time through AW then W
 * plus outstanding-response counter and sticky bus error
 */
`default_nettype none

module axi_wr_port (
	input  logic            clk_i,
	input  logic            rst_ni,
	wr_req_if.port          wr,
	output pgwr_pkg::addr_t awaddr,
	output logic            awvalid,
	input  logic            awready,
	output pgwr_pkg::line_t wdata,
	output pgwr_pkg::strb_t wstrb,
	output logic            wvalid,
	input  logic            wready,
	input  logic            bvalid,	// always accepted
	input  logic [1:0]      bresp,
	output logic            bus_error
);

	logic       aw_pend, w_pend;
	logic       acc, aw_hs, w_hs;
	logic       b_ok;
	logic [3:0] outst;	// accepted requests without a response

	assign wr.ready = !aw_pend && !w_pend;
	assign wr.done  = (outst == 4'd0);
	assign acc      = wr.valid && wr.ready;
	assign aw_hs    = awvalid && awready;
	assign w_hs     = wvalid && wready;
	assign b_ok     = bvalid && (outst != 4'd0);	// expected response
	assign awvalid  = aw_pend;
	assign wvalid   = w_pend;

	always_ff @(posedge clk_i) begin
		if (acc) begin
			awaddr <= wr.addr;
			wdata  <= wr.data;
			wstrb  <= wr.strb;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			aw_pend   <= 1'b0;
			w_pend    <= 1'b0;
			outst     <= 4'd0;
			bus_error <= 1'b0;
		end else begin
			if (acc) begin
				aw_pend <= 1'b1;
			end else if (aw_hs) begin
				aw_pend <= 1'b0;
			end
			if (aw_hs) begin
				w_pend <= 1'b1;	// W follows the address
			end else if (w_hs) begin
				w_pend <= 1'b0;
			end
			case ({acc, b_ok})
				2'b10:   outst <= outst + 4'd1;
				2'b01:   outst <= outst - 4'd1;
				default: ;
			endcase
			if (bvalid && (bresp != 2'b00 || !b_ok)) begin
				bus_error <= 1'b1;	// error or unexpected response
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/pgwr_mngr_top.sv */
/*
 * page-table write manager top, connects the FSM, generators,
 * head/tail registers and AXI write port
 */
`default_nettype none

module pgwr_mngr_top #(
	parameter int ATT_ENTRIES  = 16,
	parameter int LIST_ENTRIES = 8,
	parameter int PWRUP_UNCOMP = 0
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               init_att,
	input  logic               init_list,
	input  logic               upd_valid,
	input  pgwr_pkg::ptr_t     upd_att_id,
	input  pgwr_pkg::lst_e     upd_src,
	input  pgwr_pkg::lst_e     upd_dst,
	input  logic               upd_att_only,
	input  pgwr_pkg::att_sts_e upd_att_sts,
	input  pgwr_pkg::way_t     upd_way,
	input  pgwr_pkg::ptr_t     upd_next,
	output pgwr_pkg::addr_t    awaddr,
	output logic               awvalid,
	input  logic               awready,
	output pgwr_pkg::line_t    wdata,
	output pgwr_pkg::strb_t    wstrb,
	output logic               wvalid,
	input  logic               wready,
	input  logic               bvalid,
	input  logic [1:0]         bresp,
	output pgwr_pkg::ptr_t     free_head,
	output pgwr_pkg::ptr_t     free_tail,
	output pgwr_pkg::ptr_t     uncomp_head,
	output pgwr_pkg::ptr_t     uncomp_tail,
	output logic               init_att_done,
	output logic               init_list_done,
	output logic               mngr_ready,
	output logic               tbl_update_done,
	output logic               bus_error
);
	import pgwr_pkg::*;

	wr_req_if wr_if ();

	logic     init_step, init_last, upd_latch;
	wr_kind_e wr_kind;
	ptr_t     src_head, dst_tail;
	ht_cmd_t  ht_cmd;
	addr_t    init_addr, upd_addr;
	line_t    init_data, upd_data;
	strb_t    init_strb, upd_strb;

	pgwr_ctrl #(
		.LIST_ENTRIES (LIST_ENTRIES)
	) u_ctrl (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_att_only,
		.upd_src, .upd_dst, .upd_next,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail,
		.init_last, .init_addr, .init_data, .init_strb,
		.upd_addr, .upd_data, .upd_strb,
		.wr (wr_if.src),
		.init_step, .wr_kind, .upd_latch, .src_head, .dst_tail, .ht_cmd,
		.init_att_done, .init_list_done, .mngr_ready, .tbl_update_done
	);

	tbl_init_gen #(
		.ATT_ENTRIES  (ATT_ENTRIES),
		.LIST_ENTRIES (LIST_ENTRIES),
		.PWRUP_UNCOMP (PWRUP_UNCOMP)
	) u_init_gen (
		.clk_i, .rst_ni, .init_step,
		.init_table (wr_kind),
		.addr (init_addr), .data (init_data), .strb (init_strb),
		.last (init_last)
	);

	tbl_upd_gen u_upd_gen (
		.clk_i, .rst_ni, .upd_latch,
		.upd_att_id, .upd_src, .upd_dst, .upd_att_only, .upd_att_sts, .upd_way, .upd_next,
		.src_head, .dst_tail, .wr_kind,
		.addr (upd_addr), .data (upd_data), .strb (upd_strb)
	);

	list_ht_regs u_ht_regs (
		.clk_i, .rst_ni, .ht_cmd,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	axi_wr_port u_axi_wr (
		.clk_i, .rst_ni,
		.wr (wr_if.port),
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bvalid, .bresp, .bus_error
	);

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
/*
 * AXI write slave holding the ATT and list tables as byte arrays
 * applies wstrb on the W handshake, random AW/W ready stalls, OK response 1-4 cycles later
 */
`default_nettype none

module tb_mem_model #(
	parameter int ATT_BYTES = 128,
	parameter int LST_BYTES = 128
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  pgwr_pkg::addr_t awaddr,
	input  logic            awvalid,
	output logic            awready,
	input  pgwr_pkg::line_t wdata,
	input  pgwr_pkg::strb_t wstrb,
	input  logic            wvalid,
	output logic            wready,
	output logic            bvalid,
	output logic [1:0]      bresp
);
	timeunit 1ns;
	timeprecision 1ps;
	import pgwr_pkg::*;

	logic [7:0] att_mem [ATT_BYTES];
	logic [7:0] lst_mem [LST_BYTES];
	addr_t      aw_q;	// address of the W beat that follows
	int         b_wait [$];	// cycles left per pending response, in order
	logic       b_fire;

	initial begin
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bresp   = 2'b00;
		aw_q    = '0;
		for (int i = 0; i < ATT_BYTES; i++) begin
			att_mem[i] = 8'(i) ^ 8'h3c;	// fill differs per byte
		end
		for (int i = 0; i < LST_BYTES; i++) begin
			lst_mem[i] = 8'(i) ^ 8'hc3;
		end
	end

	// one byte into whichever table holds it, stray bytes dropped
	task automatic put_byte(addr_t a, logic [7:0] b);
		if (a >= ATT_BASE && a < ATT_BASE + addr_t'(ATT_BYTES)) begin
			att_mem[int'(a - ATT_BASE)] = b;
		end else if (a >= LIST_BASE && a < LIST_BASE + addr_t'(LST_BYTES)) begin
			lst_mem[int'(a - LIST_BASE)] = b;
		end
	endtask

	always @(posedge clk_i) begin
		b_fire = 1'b0;
		if (!rst_ni) begin
			b_wait.delete();
		end else begin
			if (awvalid && awready) begin
				aw_q = awaddr;
			end
			if (wvalid && wready) begin
				for (int i = 0; i < 16; i++) begin
					if (wstrb[i]) begin
						put_byte(aw_q + addr_t'(i), wdata[8*i +: 8]);
					end
				end
				b_wait.push_back($urandom_range(4, 1));
			end
			if (b_wait.size() > 0) begin	// only the oldest response counts down
				if (b_wait[0] <= 1) begin
					void'(b_wait.pop_front());
					b_fire = 1'b1;
				end else begin
					b_wait[0] = b_wait[0] - 1;
				end
			end
		end
		#2;
		awready = ($urandom_range(3, 0) != 0);	// ready about 3 cycles in 4
		wready  = ($urandom_range(3, 0) != 0);
		bvalid  = b_fire;
		bresp   = 2'b00;	// always OK
	end

endmodule

`default_nettype wire

/* verif/tb_pgwr_mngr.sv */
/*
 * testbench of the page-table write manager
 * clock and reset, ATT/list init and update stimulus, reference list model,
 * table and register checks and AXI handshake monitor
 */
`default_nettype none

module tb_pgwr_mngr;
	timeunit 1ns;
	timeprecision 1ps;
	import pgwr_pkg::*;

	localparam int          ATT_ENTRIES  = 16;
	localparam int          LIST_ENTRIES = 8;
	localparam int          PWRUP_UNCOMP = 0;
	localparam int          TIMEOUT      = 4000;	// about four times the worst case with stalls
	localparam logic [31:0] SEED         = 32'h228c_8351;

	logic       clk_i = 1'b0;
	logic       rst_ni;
	logic       init_att, init_list, upd_valid, upd_att_only;
	ptr_t       upd_att_id, upd_next;
	lst_e       upd_src, upd_dst;
	att_sts_e   upd_att_sts;
	way_t       upd_way;
	addr_t      awaddr;
	line_t      wdata;
	strb_t      wstrb;
	logic       awvalid, awready, wvalid, wready, bvalid;
	logic [1:0] bresp;
	ptr_t       free_head, free_tail, uncomp_head, uncomp_tail;
	logic       init_att_done, init_list_done, mngr_ready, tbl_update_done, bus_error;

	int         cycles     = 0;
	int         n_val_err  = 0;	// table and register contents
	int         n_prot_err = 0;	// handshake and bus rules
	ptr_t       m_next [1:LIST_ENTRIES];	// reference list model
	ptr_t       m_prev [1:LIST_ENTRIES];
	ptr_t       m_head [2];
	ptr_t       m_tail [2];
	att_entry_t att_exp [1:ATT_ENTRIES];
	logic       aw_hold = 1'b0;	// monitor state from the previous cycle
	logic       w_hold = 1'b0;
	addr_t      aw_prev;
	line_t      w_prev_data;
	strb_t      w_prev_strb;
	logic       done_prev = 1'b0;
	logic       berr_prev = 1'b0;
	logic       in_upd = 1'b0;

	always #20 clk_i = ~clk_i;

	pgwr_mngr_top #(
		.ATT_ENTRIES  (ATT_ENTRIES),
		.LIST_ENTRIES (LIST_ENTRIES),
		.PWRUP_UNCOMP (PWRUP_UNCOMP)
	) DUT (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_att_id, .upd_src, .upd_dst,
		.upd_att_only, .upd_att_sts, .upd_way, .upd_next,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bvalid, .bresp,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail,
		.init_att_done, .init_list_done, .mngr_ready, .tbl_update_done, .bus_error
	);

	tb_mem_model #(
		.ATT_BYTES (ATT_ENTRIES * 8),
		.LST_BYTES (LIST_ENTRIES * 16)
	) u_mem (
		.clk_i, .rst_ni, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bvalid, .bresp
	);

	task automatic next_cycle();
		@(posedge clk_i);
		#2;	// inputs change just after the edge
	endtask

	task automatic report_counts();
		$display("check summary: %0d value errors, %0d protocol errors", n_val_err, n_prot_err);
	endtask

	// ATT entries are 8 bytes each and sit two per beat
	function automatic att_entry_t att_read(int n);
		logic [63:0] w;
		for (int b = 0; b < 8; b++) begin
			w[8*b +: 8] = u_mem.att_mem[8 * (n - 1) + b];
		end
		return att_entry_t'(w);
	endfunction

	function automatic lst_entry_t lst_read(int n);
		logic [127:0] w;
		for (int b = 0; b < 16; b++) begin
			w[8*b +: 8] = u_mem.lst_mem[16 * (n - 1) + b];
		end
		return lst_entry_t'(w);
	endfunction

	function automatic logic in_tables(addr_t a);
		return (a >= ATT_BASE && a < ATT_BASE + addr_t'(ATT_ENTRIES * 8))
			|| (a >= LIST_BASE && a < LIST_BASE + addr_t'(LIST_ENTRIES * 16));
	endfunction

	task automatic check_att_table();
		att_entry_t got;
		for (int n = 1; n <= ATT_ENTRIES; n++) begin
			got = att_read(n);
			assert (got == att_exp[n]) else begin
				n_val_err++;
				$display("[ERROR] %0t ATT entry %0d is %h, expected %h", $time, n, got, att_exp[n]);
			end
		end
	endtask

	// links and way of every entry and then the head/tail outputs
	task automatic check_lists();
		lst_entry_t got;
		for (int n = 1; n <= LIST_ENTRIES; n++) begin
			got = lst_read(n);
			assert (got.next == m_next[n] && got.prev == m_prev[n]
				&& got.way == PPA_BASE + way_t'(n - 1)) else begin
				n_val_err++;
				$display("[ERROR] %0t list entry %0d next %0d prev %0d way %h, expected %0d %0d",
					$time, n, got.next, got.prev, got.way, m_next[n], m_prev[n]);
			end
		end
		assert (free_head == m_head[FREE] && free_tail == m_tail[FREE]
			&& uncomp_head == m_head[UNCOMP_LST] && uncomp_tail == m_tail[UNCOMP_LST]) else begin
			n_val_err++;
			$display("[ERROR] %0t head/tail free %0d/%0d uncomp %0d/%0d, expected %0d/%0d %0d/%0d",
				$time, free_head, free_tail, uncomp_head, uncomp_tail,
				m_head[FREE], m_tail[FREE], m_head[UNCOMP_LST], m_tail[UNCOMP_LST]);
		end
	endtask

	// pop the source head and append it to the destination tail
	task automatic model_move(lst_e s, lst_e d);
		ptr_t p;
		p = m_head[s];
		if (p == NULL_PTR) begin
			return;	// empty source leaves only the ATT write
		end
		if (p == m_tail[s]) begin
			m_head[s] = NULL_PTR;
			m_tail[s] = NULL_PTR;
		end else begin
			m_head[s] = m_next[p];
			m_prev[m_next[p]] = NULL_PTR;
		end
		m_next[p] = NULL_PTR;
		m_prev[p] = m_tail[d];
		if (m_tail[d] == NULL_PTR) begin
			m_head[d] = p;
		end else begin
			m_next[m_tail[d]] = p;
		end
		m_tail[d] = p;
	endtask

	task automatic run_update(ptr_t id, lst_e s, lst_e d, logic att_only, att_sts_e sts);
		way_t w;
		w = way_t'({$urandom(), $urandom()});
		upd_att_id   = id;
		upd_src      = s;
		upd_dst      = d;
		upd_att_only = att_only;
		upd_att_sts  = sts;
		upd_way      = w;
		upd_next     = NULL_PTR;
		if (m_head[s] != NULL_PTR) begin
			upd_next = m_next[m_head[s]];	// requester knows the popped entry's next
		end
		upd_valid = 1'b1;
		while (!mngr_ready) begin
			next_cycle();	// stays pending
		end
		next_cycle();	// taken on this edge
		upd_valid = 1'b0;
		while (!tbl_update_done) begin
			next_cycle();
		end
		if (att_only) begin
			att_exp[id].sts = sts;
		end else if (s == FREE && d == UNCOMP_LST) begin
			att_exp[id].sts = UNCOMP;
		end else begin
			att_exp[id].sts = COMP;
		end
		att_exp[id].way     = w;
		att_exp[id].zpd_cnt = '0;
		if (!att_only) begin
			model_move(s, d);
		end
		check_att_table();
		check_lists();
		next_cycle();
	endtask

	// bus and handshake monitor sampled mid-cycle
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (aw_hold) assert (awvalid && awaddr == aw_prev) else begin
				n_prot_err++;
				$display("[ERROR] %0t AW dropped or changed before awready", $time);
			end
			if (w_hold) assert (wvalid && wdata == w_prev_data && wstrb == w_prev_strb) else begin
				n_prot_err++;
				$display("[ERROR] %0t W dropped or changed before wready", $time);
			end
			if (awvalid) assert (in_tables(awaddr)) else begin
				n_prot_err++;
				$display("[ERROR] %0t write address %h outside both tables", $time, awaddr);
			end
			assert (!(bus_error && !berr_prev)) else begin
				n_prot_err++;
				$display("[ERROR] %0t bus_error raised", $time);
			end
			if (in_upd) assert (!mngr_ready) else begin
				n_prot_err++;
				$display("[ERROR] %0t mngr_ready high during an update", $time);
			end
			if (done_prev) assert (!tbl_update_done && mngr_ready) else begin
				n_prot_err++;
				$display("[ERROR] %0t tbl_update_done longer than one cycle or not ready", $time);
			end
			if (tbl_update_done) assert (in_upd) else begin
				n_prot_err++;
				$display("[ERROR] %0t tbl_update_done without an update", $time);
			end
		end
		if (tbl_update_done) begin
			in_upd = 1'b0;
		end
		if (upd_valid && mngr_ready) begin
			in_upd = 1'b1;	// accepted on the coming edge
		end
		aw_hold     = awvalid && !awready;
		aw_prev     = awaddr;
		w_hold      = wvalid && !wready;
		w_prev_data = wdata;
		w_prev_strb = wstrb;
		done_prev   = tbl_update_done;
		berr_prev   = bus_error;
	end

	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		report_counts();
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(SEED));	// one seed for the whole run
		rst_ni       = 1'b0;
		init_att     = 1'b0;
		init_list    = 1'b0;
		upd_valid    = 1'b0;
		upd_att_id   = NULL_PTR;
		upd_src      = FREE;
		upd_dst      = FREE;
		upd_att_only = 1'b0;
		upd_att_sts  = DALLOC;
		upd_way      = '0;
		upd_next     = NULL_PTR;
		repeat (8) @(posedge clk_i);
		#2 rst_ni = 1'b1;
		assert (mngr_ready && !awvalid && !wvalid && !init_att_done && !init_list_done
			&& !tbl_update_done && !bus_error && free_head == NULL_PTR
			&& free_tail == NULL_PTR && uncomp_head == NULL_PTR && uncomp_tail == NULL_PTR)
		else begin
			n_val_err++;
			$display("[ERROR] %0t outputs not at their reset values", $time);
		end

		init_att = 1'b1;
		while (!init_att_done) begin
			next_cycle();
		end
		init_att = 1'b0;
		for (int n = 1; n <= ATT_ENTRIES; n++) begin
			att_exp[n].zpd_cnt = '0;
			if (PWRUP_UNCOMP == 1 && n <= LIST_ENTRIES) begin
				att_exp[n].sts = UNCOMP;
				att_exp[n].way = PPA_BASE + way_t'(n - 1);
			end else begin
				att_exp[n].sts = DALLOC;
				att_exp[n].way = '0;
			end
		end
		check_att_table();

		init_list = 1'b1;
		while (!init_list_done) begin
			next_cycle();
		end
		init_list = 1'b0;
		for (int n = 1; n <= LIST_ENTRIES; n++) begin	// one free list 1..N
			m_prev[n] = ptr_t'(n - 1);
			m_next[n] = (n == LIST_ENTRIES) ? NULL_PTR : ptr_t'(n + 1);
		end
		m_head[FREE]       = 32'd1;
		m_tail[FREE]       = ptr_t'(LIST_ENTRIES);
		m_head[UNCOMP_LST] = NULL_PTR;
		m_tail[UNCOMP_LST] = NULL_PTR;
		check_lists();
		next_cycle();

		run_update(32'd3, FREE, UNCOMP_LST, 1'b0, DALLOC);	// into an empty list
		run_update(32'd4, FREE, UNCOMP_LST, 1'b0, DALLOC);	// needs the link write
		run_update(32'd3, UNCOMP_LST, UNCOMP_LST, 1'b0, DALLOC);	// head rotates to tail
		run_update(32'd9, FREE, FREE, 1'b1, UNCOMP);
		run_update(32'd4, UNCOMP_LST, FREE, 1'b0, DALLOC);
		run_update(32'd3, UNCOMP_LST, FREE, 1'b0, DALLOC);	// single-entry source empties
		repeat (4) next_cycle();

		report_counts();
		if (n_val_err + n_prot_err == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/pgwr_pkg.sv
common/wr_req_if.sv
pgwr/list_ht_regs.sv
pgwr/tbl_init_gen.sv
pgwr/tbl_upd_gen.sv
pgwr/pgwr_ctrl.sv
rtl/axi_wr_port.sv
rtl/pgwr_mngr_top.sv
verif/tb_mem_model.sv
verif/tb_pgwr_mngr.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pgwr_mngr -Mdir obj_dir -f sim.f || exit 1

out=$(./obj_dir/Vtb_pgwr_mngr)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
